//--- gemm_pkg.sv
package gemm_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] mask_t;
  typedef logic [7:0] byte_t;
  typedef logic [127:0] line_t;  // byte n sits at bits 8n+7 down to 8n

  typedef logic signed [7:0] elem_t;
  typedef logic signed [31:0] acc_t;

  // top address nibble of the accelerator register window
  localparam logic [3:0] GEMM_REGION = 4'h9;

  localparam logic [7:0] CSR_CTRL = 8'h00;
  localparam logic [7:0] CSR_STATUS = 8'h04;  // bit 0 busy, bit 1 done
  localparam logic [7:0] CSR_A_ADDR = 8'h08;
  localparam logic [7:0] CSR_B_ADDR = 8'h0C;
  localparam logic [7:0] CSR_C_ADDR = 8'h10;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_A,
    FETCH_B,
    WAIT_B,  // B line comes back from the banks here
    WRITE_ROW,
    FINISH
  } engine_state_t;

endpackage

//--- byte_ram.sv
`timescale 1ns/100ps
module byte_ram #(
  parameter int A_WID = 10,
  parameter int D_WID = 8
) (
  input  logic             clk,
  input  logic             a_en,
  input  logic             a_we,
  input  logic [A_WID-1:0] a_addr,
  input  logic [D_WID-1:0] a_wr_data,
  output logic [D_WID-1:0] a_rd_data,
  input  logic             b_en,
  input  logic             b_we,
  input  logic [A_WID-1:0] b_addr,
  input  logic [D_WID-1:0] b_wr_data,
  output logic [D_WID-1:0] b_rd_data
);

  logic [D_WID-1:0] mem [2**A_WID];

  // port b is applied last, so it wins a same-row write collision
  always_ff @(posedge clk) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_addr] <= a_wr_data;
        a_rd_data <= a_wr_data;  // write-first
      end else begin
        a_rd_data <= mem[a_addr];
      end
    end
    if (b_en) begin
      if (b_we) begin
        mem[b_addr] <= b_wr_data;
        b_rd_data <= b_wr_data;
      end else begin
        b_rd_data <= mem[b_addr];
      end
    end
  end

endmodule

//--- banked_memory.sv
`timescale 1ns/100ps
module banked_memory
  import gemm_pkg::*;
#(
  parameter int NUM_RAMS = 16,
  parameter int A_WID = 10,
  parameter int D_WID = 8
) (
  input  logic  clk,
  input  logic  mem_en,
  input  logic  bus_rdwr,
  input  mask_t bus_mask,
  input  addr_t bus_addr,
  input  word_t bus_wr_data,
  output word_t mem_rd_data,
  input  logic  line_en,
  input  logic  line_rdwr,
  input  addr_t line_addr,
  input  line_t line_wr_data,
  output line_t line_rd_data
);

  logic [1:0] group;
  logic [1:0] group_q;
  logic [A_WID-1:0] sys_row;
  logic [A_WID-1:0] line_row;
  byte_t sys_byte [NUM_RAMS];

  assign group = bus_addr[3:2];
  assign sys_row = bus_addr[A_WID+3:4];
  assign line_row = line_addr[A_WID+3:4];  // same row in every bank

  always_ff @(posedge clk) begin
    if (mem_en) group_q <= group;  // selects the bytes returned next cycle
  end

  always_comb begin
    for (int i = 0; i < 4; i++) mem_rd_data[8*i +: 8] = sys_byte[4 * group_q + i];
  end

  for (genvar n = 0; n < NUM_RAMS; n++) begin : g_bank
    localparam logic [1:0] GRP = 2'(n / 4);
    localparam int LANE = n % 4;

    byte_ram #(
      .A_WID(A_WID),
      .D_WID(D_WID)
    ) u_ram (
      .clk      (clk),
      .a_en     (mem_en && (group == GRP)),
      .a_we     (bus_rdwr && bus_mask[LANE]),
      .a_addr   (sys_row),
      .a_wr_data(bus_wr_data[8*LANE +: 8]),
      .a_rd_data(sys_byte[n]),
      .b_en     (line_en),
      .b_we     (line_rdwr),
      .b_addr   (line_row),
      .b_wr_data(line_wr_data[8*n +: 8]),
      .b_rd_data(line_rd_data[8*n +: 8])
    );
  end

endmodule

//--- gemm_row_mac.sv
`timescale 1ns/100ps
module gemm_row_mac
  import gemm_pkg::*;
(
  input  logic [31:0] a_row,
  input  line_t       b_mat,
  output line_t       c_row
);

  // B is row-major, so element (k, j) is byte 4k + j of the line
  always_comb begin
    acc_t sum;
    elem_t ea;
    elem_t eb;
    for (int j = 0; j < 4; j++) begin
      sum = '0;
      for (int k = 0; k < 4; k++) begin
        ea = elem_t'(a_row[8*k +: 8]);
        eb = elem_t'(b_mat[8*(4*k + j) +: 8]);
        sum = sum + acc_t'(ea) * acc_t'(eb);  // wraps in 32 bits
      end
      c_row[32*j +: 32] = sum;
    end
  end

endmodule

//--- gemm_engine.sv
`timescale 1ns/100ps
module gemm_engine
  import gemm_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  addr_t a_addr,
  input  addr_t b_addr,
  input  addr_t c_addr,
  output logic  busy,
  output logic  finish,
  output logic  line_en,
  output logic  line_rdwr,
  output addr_t line_addr,
  output line_t line_wr_data,
  input  line_t line_rd_data
);

  engine_state_t state;
  engine_state_t state_next;
  logic [1:0] row;
  line_t a_line;
  line_t b_line;
  logic [31:0] a_row;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (start) state_next = FETCH_A;
      FETCH_A: state_next = FETCH_B;
      FETCH_B: state_next = WAIT_B;
      WAIT_B: state_next = WRITE_ROW;
      WRITE_ROW: if (row == 2'd3) state_next = FINISH;
      FINISH: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      row <= 2'd0;
    end else begin
      state <= state_next;
      if (state == IDLE) row <= 2'd0;
      else if (state == WRITE_ROW) row <= row + 2'd1;
    end
  end

  // each line arrives one cycle after its fetch was issued
  always_ff @(posedge clk) begin
    if (state == FETCH_B) a_line <= line_rd_data;
    if (state == WAIT_B) b_line <= line_rd_data;
  end

  always_comb begin
    line_en = 1'b0;
    line_rdwr = 1'b0;
    line_addr = '0;
    case (state)
      FETCH_A: begin
        line_en = 1'b1;
        line_addr = {a_addr[31:4], 4'h0};
      end
      FETCH_B: begin
        line_en = 1'b1;
        line_addr = {b_addr[31:4], 4'h0};
      end
      WRITE_ROW: begin
        line_en = 1'b1;
        line_rdwr = 1'b1;
        line_addr = {c_addr[31:4], 4'h0} + addr_t'({row, 4'h0});  // one line per row of C
      end
      default: ;
    endcase
  end

  assign a_row = a_line[32*row +: 32];
  assign busy = state != IDLE;
  assign finish = state == FINISH;

  gemm_row_mac u_mac (
    .a_row(a_row),
    .b_mat(b_line),
    .c_row(line_wr_data)
  );

endmodule

//--- gemm_accel.sv
`timescale 1ns/100ps
module gemm_accel
  import gemm_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  csr_en,
  input  logic  bus_rdwr,
  input  addr_t bus_addr,
  input  word_t bus_wr_data,
  output word_t csr_rd_data,
  output logic  line_en,
  output logic  line_rdwr,
  output addr_t line_addr,
  output line_t line_wr_data,
  input  line_t line_rd_data,
  output logic  irq
);

  addr_t a_base;
  addr_t b_base;
  addr_t c_base;
  logic busy;
  logic done;
  logic finish;
  logic csr_wr;
  logic start;

  assign csr_wr = csr_en && bus_rdwr;
  assign start = csr_wr && (bus_addr[7:0] == CSR_CTRL) && bus_wr_data[0] && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_base <= '0;
      b_base <= '0;
      c_base <= '0;
      done <= 1'b0;
      irq <= 1'b0;
    end else begin
      if (csr_wr) begin
        case (bus_addr[7:0])
          CSR_A_ADDR: a_base <= bus_wr_data;
          CSR_B_ADDR: b_base <= bus_wr_data;
          CSR_C_ADDR: c_base <= bus_wr_data;
          default: ;
        endcase
      end
      if (start) done <= 1'b0;
      else if (finish) done <= 1'b1;  // sticky until the next start
      irq <= finish;
    end
  end

  always_comb begin
    case (bus_addr[7:0])
      CSR_STATUS: csr_rd_data = {30'd0, done, busy};
      CSR_A_ADDR: csr_rd_data = a_base;
      CSR_B_ADDR: csr_rd_data = b_base;
      CSR_C_ADDR: csr_rd_data = c_base;
      default: csr_rd_data = '0;  // CTRL reads back as zero
    endcase
  end

  gemm_engine u_engine (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .a_addr      (a_base),
    .b_addr      (b_base),
    .c_addr      (c_base),
    .busy        (busy),
    .finish      (finish),
    .line_en     (line_en),
    .line_rdwr   (line_rdwr),
    .line_addr   (line_addr),
    .line_wr_data(line_wr_data),
    .line_rd_data(line_rd_data)
  );

endmodule

//--- soc_top.sv
`timescale 1ns/100ps
module soc_top
  import gemm_pkg::*;
#(
  parameter int NUM_RAMS = 16,
  parameter int A_WID = 10,
  parameter int D_WID = 8
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  bus_en,
  input  logic  bus_rdwr,
  input  mask_t bus_mask,
  input  addr_t bus_addr,
  input  word_t bus_wr_data,
  output word_t bus_rd_data,
  output logic  bus_valid,
  output logic  irq
);

  logic is_gemm;
  logic is_gemm_q;
  logic csr_en;
  logic mem_en;
  addr_t word_addr;
  word_t csr_rd_data;
  word_t csr_rd_q;
  word_t mem_rd_data;

  logic line_en;
  logic line_rdwr;
  addr_t line_addr;
  line_t line_wr_data;
  line_t line_rd_data;

  assign word_addr = {bus_addr[31:2], 2'b00};
  assign is_gemm = bus_addr[31:28] == GEMM_REGION;
  assign csr_en = bus_en && is_gemm;
  assign mem_en = bus_en && !is_gemm;

  always_ff @(posedge clk) begin
    if (reset) begin
      bus_valid <= 1'b0;
      is_gemm_q <= 1'b0;
    end else begin
      bus_valid <= bus_en && !bus_rdwr;  // reads only, writes give no strobe
      is_gemm_q <= is_gemm;
    end
  end

  always_ff @(posedge clk) begin
    csr_rd_q <= csr_rd_data;  // lines up with the registered bank output
  end

  assign bus_rd_data = is_gemm_q ? csr_rd_q : mem_rd_data;

  banked_memory #(
    .NUM_RAMS(NUM_RAMS),
    .A_WID   (A_WID),
    .D_WID   (D_WID)
  ) u_memory (
    .clk         (clk),
    .mem_en      (mem_en),
    .bus_rdwr    (bus_rdwr),
    .bus_mask    (bus_mask),
    .bus_addr    (word_addr),
    .bus_wr_data (bus_wr_data),
    .mem_rd_data (mem_rd_data),
    .line_en     (line_en),
    .line_rdwr   (line_rdwr),
    .line_addr   (line_addr),
    .line_wr_data(line_wr_data),
    .line_rd_data(line_rd_data)
  );

  gemm_accel u_accel (
    .clk         (clk),
    .reset       (reset),
    .csr_en      (csr_en),
    .bus_rdwr    (bus_rdwr),
    .bus_addr    (word_addr),
    .bus_wr_data (bus_wr_data),
    .csr_rd_data (csr_rd_data),
    .line_en     (line_en),
    .line_rdwr   (line_rdwr),
    .line_addr   (line_addr),
    .line_wr_data(line_wr_data),
    .line_rd_data(line_rd_data),
    .irq         (irq)
  );

endmodule

//--- tb_soc_tasks.svh
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

task automatic check_value(input string name, input word_t got, input word_t expected);
  checks++;
  assert (got === expected)
  else begin
    errors++;
    $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, expected);
  end
endtask

function automatic addr_t csr_addr(input logic [7:0] offset);
  return {GEMM_REGION, 20'd0, offset};
endfunction

// request is driven in the current slot and accepted at the next rising edge
task automatic bus_write(input addr_t addr, input word_t data, input mask_t mask);
  bus_en = 1'b1;
  bus_rdwr = 1'b1;
  bus_mask = mask;
  bus_addr = addr;
  bus_wr_data = data;
  @(posedge clk);
  #2;
  check_value("bus_valid", bus_valid, '0);
  bus_en = 1'b0;
endtask

task automatic bus_read(input addr_t addr, output word_t data);
  bus_en = 1'b1;
  bus_rdwr = 1'b0;
  bus_mask = '0;
  bus_addr = addr;
  @(posedge clk);
  #2;
  check_value("bus_valid", bus_valid, 32'd1);
  data = bus_rd_data;
  bus_en = 1'b0;
  @(posedge clk);
  #2;
  check_value("bus_valid", bus_valid, '0);  // the strobe lasts one cycle only
endtask

task automatic read_check(input addr_t addr, input word_t expected, input string name);
  word_t data;
  bus_read(addr, data);
  check_value(name, data, expected);
endtask

// C(i, j) is the sum over k of A(i, k) * B(k, j), wrapping in 32 bits
function automatic word_t ref_elem(input int i, input int j);
  int sum;
  sum = 0;
  for (int k = 0; k < 4; k++) begin
    sum += int'(a_mat[4*i + k]) * int'(b_mat[4*k + j]);
  end
  return word_t'(sum);
endfunction

task automatic load_matrices(input addr_t a_base, input addr_t b_base);
  word_t a_word;
  word_t b_word;
  for (int w = 0; w < 4; w++) begin
    a_word = {a_mat[4*w + 3], a_mat[4*w + 2], a_mat[4*w + 1], a_mat[4*w]};
    b_word = {b_mat[4*w + 3], b_mat[4*w + 2], b_mat[4*w + 1], b_mat[4*w]};
    bus_write(a_base + 4*w, a_word, 4'hF);
    bus_write(b_base + 4*w, b_word, 4'hF);
  end
endtask

task automatic check_product(input addr_t c_base);
  for (int i = 0; i < 4; i++) begin
    for (int j = 0; j < 4; j++) begin
      read_check(c_base + 16*i + 4*j, ref_elem(i, j), $sformatf("C[%0d][%0d]", i, j));
    end
  end
endtask

task automatic wait_irq();
  int waited;
  waited = 0;
  while (!irq && waited < IRQ_TIMEOUT) begin
    @(posedge clk);
    #2;
    waited++;
  end
  if (!irq) begin
    errors++;
    $display("timeout: the accelerator raised no interrupt within %0d cycles", IRQ_TIMEOUT);
  end
endtask

`endif

//--- tb_soc_top.sv
`timescale 1ns/100ps
module tb_soc_top
  import gemm_pkg::*;
();

  localparam int IRQ_TIMEOUT = 40;

  logic clk;
  logic reset;
  logic bus_en;
  logic bus_rdwr;
  mask_t bus_mask;
  addr_t bus_addr;
  word_t bus_wr_data;
  word_t bus_rd_data;
  logic bus_valid;
  logic irq;

  integer seed;
  int errors;
  int checks;
  int cycle_cnt;
  int irq_pulses;
  elem_t a_mat [16];
  elem_t b_mat [16];

  `include "tb_soc_tasks.svh"

  soc_top #(
    .NUM_RAMS(16),
    .A_WID   (10),
    .D_WID   (8)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .bus_en     (bus_en),
    .bus_rdwr   (bus_rdwr),
    .bus_mask   (bus_mask),
    .bus_addr   (bus_addr),
    .bus_wr_data(bus_wr_data),
    .bus_rd_data(bus_rd_data),
    .bus_valid  (bus_valid),
    .irq        (irq)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  always @(negedge clk) begin
    if (irq) irq_pulses++;  // counts every cycle the interrupt is high
  end

  task automatic test_reset_state();
    check_value("bus_valid", bus_valid, '0);
    check_value("irq", irq, '0);
    read_check(csr_addr(CSR_STATUS), '0, "STATUS");
  endtask

  task automatic test_word_rw();
    addr_t addr;
    word_t data;
    for (int n = 0; n < 8; n++) begin
      addr = addr_t'($random(seed)) & 32'h0000_3FFC;
      data = word_t'($random(seed));
      bus_write(addr, data, 4'hF);
      read_check(addr, data, "bus_rd_data");
    end
  endtask

  task automatic test_masked_write();
    addr_t addr;
    word_t old_word;
    word_t new_word;
    word_t expected;
    mask_t mask;
    for (int n = 0; n < 6; n++) begin
      addr = addr_t'($random(seed)) & 32'h0000_3FFC;
      old_word = word_t'($random(seed));
      new_word = word_t'($random(seed));
      mask = mask_t'($random(seed));
      for (int i = 0; i < 4; i++) begin
        expected[8*i +: 8] = mask[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
      end
      bus_write(addr, old_word, 4'hF);
      bus_write(addr, new_word, mask);
      read_check(addr, expected, "bus_rd_data");
    end
  endtask

  task automatic test_csr_readback();
    bus_write(32'h0000_0008, 32'h5A5A_A5A5, 4'hF);  // same offset as A_ADDR, in memory
    bus_write(csr_addr(CSR_A_ADDR), 32'h0000_1230, 4'hF);
    bus_write(csr_addr(CSR_B_ADDR), 32'h0000_4560, 4'hF);
    bus_write(csr_addr(CSR_C_ADDR), 32'h0000_7890, 4'hF);
    read_check(csr_addr(CSR_A_ADDR), 32'h0000_1230, "A_ADDR");
    read_check(csr_addr(CSR_B_ADDR), 32'h0000_4560, "B_ADDR");
    read_check(csr_addr(CSR_C_ADDR), 32'h0000_7890, "C_ADDR");
    read_check(32'h0000_0008, 32'h5A5A_A5A5, "bus_rd_data");
  endtask

  task automatic run_gemm(input addr_t a_base, input addr_t b_base, input addr_t c_base,
                          input bit poke_busy);
    int start_cycle;
    word_t data;
    load_matrices(a_base, b_base);
    bus_write(csr_addr(CSR_A_ADDR), a_base, 4'hF);
    bus_write(csr_addr(CSR_B_ADDR), b_base, 4'hF);
    bus_write(csr_addr(CSR_C_ADDR), c_base, 4'hF);
    irq_pulses = 0;
    bus_write(csr_addr(CSR_CTRL), 32'd1, 4'hF);
    start_cycle = cycle_cnt;  // edge that accepted the start
    if (poke_busy) begin
      bus_read(csr_addr(CSR_STATUS), data);
      check_value("STATUS", data, 32'd1);  // busy, done cleared by the start
      repeat (7 - (cycle_cnt - start_cycle)) begin
        @(posedge clk);
        #2;
      end
      // accepted in the last busy cycle, where a start would wipe the new done
      bus_write(csr_addr(CSR_CTRL), 32'd1, 4'hF);
    end
    wait_irq();
    check_value("irq latency", cycle_cnt - start_cycle, 32'd8);
    repeat (12) begin
      @(posedge clk);
      #2;
    end
    check_value("irq pulses", irq_pulses, 32'd1);
    read_check(csr_addr(CSR_STATUS), 32'd2, "STATUS");
    check_product(c_base);
  endtask

  task automatic test_gemm_random();
    for (int n = 0; n < 16; n++) begin
      a_mat[n] = elem_t'($random(seed));
      b_mat[n] = elem_t'($random(seed));
    end
    run_gemm(32'h0000_0100, 32'h0000_0110, 32'h0000_0200, 1'b0);
  endtask

  task automatic test_gemm_extreme();
    for (int n = 0; n < 16; n++) begin
      a_mat[n] = ($random(seed) & 1) ? elem_t'(8'h7F) : elem_t'(8'h80);
      b_mat[n] = ($random(seed) & 1) ? elem_t'(8'h7F) : elem_t'(8'h80);
    end
    for (int k = 0; k < 4; k++) begin
      a_mat[k] = elem_t'(8'h80);  // row 0 of A and column 0 of B at the minimum
      b_mat[4*k] = elem_t'(8'h80);
    end
    run_gemm(32'h0000_0400, 32'h0000_0410, 32'h0000_0600, 1'b1);
  endtask

  initial begin
    seed = 32'h9244;
    errors = 0;
    checks = 0;
    cycle_cnt = 0;
    irq_pulses = 0;
    clk = 1'b0;
    reset = 1'b1;
    bus_en = 1'b0;
    bus_rdwr = 1'b0;
    bus_mask = '0;
    bus_addr = '0;
    bus_wr_data = '0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_word_rw();
    test_masked_write();
    test_csr_readback();
    test_gemm_random();
    test_gemm_extreme();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
gemm_pkg.sv
byte_ram.sv
banked_memory.sv
gemm_row_mac.sv
gemm_engine.sv
gemm_accel.sv
soc_top.sv
tb_soc_top.sv
